/* common/bch_pkg.sv */
`default_nettype none

package bch_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Field and code constants
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Symbol width of GF(2^4)
	localparam int GF_M = 4;

	// Multiplicative group order, also the full code length
	localparam int GF_ORDER = (2 ** GF_M) - 1;

	// Largest supported number of correctable errors
	localparam int MAX_T = 3;

	// Primitive polynomial x^4+x+1
	localparam logic [GF_M:0] GF_POLY = 5'b10011;

	// Minimal polynomials of alpha and alpha^3
	localparam logic [GF_M:0] M1_POLY = GF_POLY;
	localparam logic [GF_M:0] M3_POLY = 5'b11111;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Field element in polynomial basis
	typedef logic [GF_M-1:0] gf_elem_t;

	// Primitive element alpha = x
	localparam gf_elem_t GF_ALPHA = 4'b0010;

	// One serial bit event
	typedef struct packed {
		logic ce;
		logic first;
		logic last;
		logic data;
	} bch_bit_t;

	// Remainders of the received word mod m1 and mod m3
	typedef struct packed {
		gf_elem_t rem1;
		gf_elem_t rem3;
	} bch_rem_t;

	// Syndrome set, S1 in the low nibble
	typedef struct packed {
		gf_elem_t s6;
		gf_elem_t s5;
		gf_elem_t s4;
		gf_elem_t s3;
		gf_elem_t s2;
		gf_elem_t s1;
	} bch_syn_set_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// GF(16) arithmetic
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Carry-less product followed by reduction with GF_POLY
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		logic [2*GF_M-2:0] prod;
		logic [2*GF_M-2:0] poly_ext;
		prod = '0;
		poly_ext = {{(GF_M-2){1'b0}}, GF_POLY};
		for (int i = 0; i < GF_M; i++) begin
			if (b[i])
				prod = prod ^ ({{(GF_M-1){1'b0}}, a} << i);
		end
		for (int k = 2*GF_M-2; k >= GF_M; k--) begin
			if (prod[k])
				prod = prod ^ (poly_ext << (k - GF_M));
		end
		return prod[GF_M-1:0];
	endfunction

	function automatic gf_elem_t gf_sq(input gf_elem_t a);
		return gf_mul(a, a);
	endfunction

	// alpha^n, exponent taken modulo the group order
	function automatic gf_elem_t gf_alpha_pow(input int unsigned n);
		gf_elem_t result;
		int unsigned e;
		result = 4'b0001;
		e = n % GF_ORDER;
		for (int unsigned i = 0; i < GF_ORDER; i++) begin
			if (i < e)
				result = gf_mul(result, GF_ALPHA);
		end
		return result;
	endfunction

endpackage

`default_nettype wire

/* bch_syndrome/bch_syn_remainder.sv */
`timescale 1ns/1ps
`default_nettype none

// Serial division of the received word by m1 and m3.
// Bits arrive highest-order coefficient first, so every step is
// r = (r * x + d) mod m.
module bch_syn_remainder (
	input  logic              clk,
	input  logic              rst_n,
	input  bch_pkg::bch_bit_t bit_in,
	output bch_pkg::bch_rem_t rem
);

	// One LFSR step, shift in a bit and reduce by poly
	function automatic bch_pkg::gf_elem_t rem_step(
		input bch_pkg::gf_elem_t           r,
		input logic                        d,
		input logic [bch_pkg::GF_M:0]      poly
	);
		logic [bch_pkg::GF_M:0] t;
		t = {r, d};
		if (t[bch_pkg::GF_M])
			t = t ^ poly;
		return t[bch_pkg::GF_M-1:0];
	endfunction

	bch_pkg::gf_elem_t rem1_q;
	bch_pkg::gf_elem_t rem3_q;
	bch_pkg::gf_elem_t rem1_base;
	bch_pkg::gf_elem_t rem3_base;

	// A first bit starts over from an empty remainder
	assign rem1_base = bit_in.first ? '0 : rem1_q;
	assign rem3_base = bit_in.first ? '0 : rem3_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// LFSR state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rem1_q <= '0;
			rem3_q <= '0;
		end else if (bit_in.ce) begin
			rem1_q <= rem_step(rem1_base, bit_in.data, bch_pkg::M1_POLY);
			rem3_q <= rem_step(rem3_base, bit_in.data, bch_pkg::M3_POLY);
		end
	end

	assign rem.rem1 = rem1_q;
	assign rem.rem3 = rem3_q;

endmodule

`default_nettype wire

/* bch_syndrome/bch_syn_horner.sv */
`timescale 1ns/1ps
`default_nettype none

// Direct evaluation of the received word at alpha^5.
// Horner form, acc = acc * alpha^5 + d for every accepted bit.
module bch_syn_horner #(
	parameter int T = 3
) (
	input  logic              clk,
	input  logic              rst_n,
	input  bch_pkg::bch_bit_t bit_in,
	output bch_pkg::gf_elem_t s5
);

	localparam bch_pkg::gf_elem_t ALPHA5 = bch_pkg::gf_alpha_pow(5);

	generate
	if (T >= 3) begin : g_acc
		bch_pkg::gf_elem_t acc_q;
		bch_pkg::gf_elem_t acc_base;
		bch_pkg::gf_elem_t din_elem;

		// First bit loads into a cleared accumulator
		assign acc_base = bit_in.first ? '0 : acc_q;

		// Received bit as a field element, 0 or 1
		assign din_elem = {{(bch_pkg::GF_M-1){1'b0}}, bit_in.data};

		always_ff @(posedge clk) begin
			if (!rst_n) begin
				acc_q <= '0;
			end else if (bit_in.ce) begin
				acc_q <= bch_pkg::gf_mul(acc_base, ALPHA5) ^ din_elem;
			end
		end

		assign s5 = acc_q;
	end else begin : g_no_acc
		// S5 is outside the syndrome set for T = 2
		assign s5 = '0;
	end
	endgenerate

endmodule

`default_nettype wire

/* bch_syndrome/bch_syn_assemble.sv */
`timescale 1ns/1ps
`default_nettype none

// Turns the remainders and S5 into the full syndrome set.
// Odd syndromes come from the remainder bank and the Horner block,
// even ones by squaring (S2j = Sj^2).
module bch_syn_assemble #(
	parameter int T = 3
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  bch_pkg::bch_bit_t     bit_in,
	input  bch_pkg::bch_rem_t     rem,
	input  bch_pkg::gf_elem_t     s5,
	output bch_pkg::bch_syn_set_t syn,
	output logic                  done,
	output logic                  error_free
);

	generate
	if (T < 2 || T > bch_pkg::MAX_T) begin : g_bad_t
		$error("bch_syn_assemble supports T of 2 or 3 only");
	end
	endgenerate

	// Evaluate a remainder mod m3 at alpha^3
	function automatic bch_pkg::gf_elem_t eval_at_alpha3(input bch_pkg::gf_elem_t r);
		bch_pkg::gf_elem_t acc;
		acc = '0;
		for (int k = 0; k < bch_pkg::GF_M; k++) begin
			if (r[k])
				acc = acc ^ bch_pkg::gf_alpha_pow(3 * k);
		end
		return acc;
	endfunction

	bch_pkg::gf_elem_t     s1;
	bch_pkg::gf_elem_t     s2;
	bch_pkg::gf_elem_t     s3;
	bch_pkg::bch_syn_set_t syn_d;
	logic                  last_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Syndrome conversion
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// In polynomial basis rem1 at alpha is rem1 itself
	assign s1 = rem.rem1;
	assign s2 = bch_pkg::gf_sq(s1);
	assign s3 = eval_at_alpha3(rem.rem3);

	always_comb begin
		syn_d.s1 = s1;
		syn_d.s2 = s2;
		syn_d.s3 = s3;
		syn_d.s4 = bch_pkg::gf_sq(s2);
		if (T >= 3) begin
			syn_d.s5 = s5;
			syn_d.s6 = bch_pkg::gf_sq(s3);
		end else begin
			syn_d.s5 = '0;
			syn_d.s6 = '0;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Result capture
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// The last bit reaches the state registers one cycle after its ce,
	// so the set is taken on the cycle after last_q
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			last_q     <= 1'b0;
			done       <= 1'b0;
			error_free <= 1'b0;
			syn        <= '0;
		end else begin
			last_q <= bit_in.ce & bit_in.last;
			done   <= last_q;
			if (last_q) begin
				syn        <= syn_d;
				error_free <= (syn_d == '0);
			end
		end
	end

endmodule

`default_nettype wire

/* bch_syndrome/bch_syndrome_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Syndrome front end of the GF(16) BCH decoder
module bch_syndrome_top #(
	parameter int T = 3
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  bch_pkg::bch_bit_t     bit_in,
	output bch_pkg::bch_syn_set_t syn,
	output logic                  done,
	output logic                  error_free
);

	bch_pkg::bch_rem_t rem;
	bch_pkg::gf_elem_t s5;

	// Remainders mod m1 and m3 for S1 and S3
	bch_syn_remainder i_remainder (
		.clk    (clk),
		.rst_n  (rst_n),
		.bit_in (bit_in),
		.rem    (rem)
	);

	// S5 straight from the bit stream
	bch_syn_horner #(
		.T (T)
	) i_horner (
		.clk    (clk),
		.rst_n  (rst_n),
		.bit_in (bit_in),
		.s5     (s5)
	);

	bch_syn_assemble #(
		.T (T)
	) i_assemble (
		.clk        (clk),
		.rst_n      (rst_n),
		.bit_in     (bit_in),
		.rem        (rem),
		.s5         (s5),
		.syn        (syn),
		.done       (done),
		.error_free (error_free)
	);

endmodule

`default_nettype wire

/* dv/bch_syndrome_chk.sv */
`timescale 1ns/1ps
`default_nettype none

// Protocol checks on the syndrome top level
module bch_syndrome_chk (
	input logic                  clk,
	input logic                  rst_n,
	input bch_pkg::bch_bit_t     bit_in,
	input bch_pkg::bch_syn_set_t syn,
	input logic                  done,
	input logic                  error_free
);

	logic last_accepted;

	// Last bit of a word taken on this edge
	assign last_accepted = bit_in.ce & bit_in.last;

	// done is a single-cycle pulse
	a_done_pulse: assert property (
		@(posedge clk) disable iff (!rst_n)
		done |=> !done
	) else $error("done stayed high for more than one cycle");

	// Every accepted last bit gets its done two cycles later
	a_done_after_last: assert property (
		@(posedge clk) disable iff (!rst_n)
		$past(last_accepted, 2) |-> done
	) else $error("done missing two cycles after an accepted last bit");

	// and no done without one
	a_done_has_cause: assert property (
		@(posedge clk) disable iff (!rst_n)
		done |-> $past(last_accepted, 2)
	) else $error("done without an accepted last bit two cycles before");

	a_clean_syn: assert property (
		@(posedge clk) disable iff (!rst_n)
		error_free |-> (syn == '0)
	) else $error("error_free set while a syndrome is nonzero");

endmodule

`default_nettype wire

/* dv/bch_syndrome_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module bch_syndrome_tb;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	localparam int CODE_LEN = 15;
	localparam int NUM_TESTS = 43;
	localparam int CYCLES_PER_TEST = 40;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST;

	// BCH(15,5) generator is m1 * m3 * m5
	localparam logic [10:0] GEN_POLY = 11'b101_0011_0111;

	logic                  clk;
	logic                  rst_n;
	bch_pkg::bch_bit_t     bit_in;
	bch_pkg::bch_syn_set_t syn;
	logic                  done;
	logic                  error_free;

	bch_pkg::gf_elem_t     exp_tab [CODE_LEN];
	bch_pkg::bch_syn_set_t exp_q [$];
	int                    due_q [$];
	int                    cyc = 0;
	int                    error_count;
	integer                seed;
	bch_pkg::bch_syn_set_t held_syn = '0;
	logic                  held_ef = 1'b0;
	bch_pkg::bch_syn_set_t mon_exp;
	int                    mon_due;

	bch_syndrome_top #(
		.T (3)
	) i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.bit_in     (bit_in),
		.syn        (syn),
		.done       (done),
		.error_free (error_free)
	);

	bind bch_syndrome_top bch_syndrome_chk i_chk (
		.clk        (clk),
		.rst_n      (rst_n),
		.bit_in     (bit_in),
		.syn        (syn),
		.done       (done),
		.error_free (error_free)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Cycle count read by the stimulus on the falling edge
	always @(posedge clk) cyc <= cyc + 1;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reporting and checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic report_failure;
		$display("Test failures found");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_elem(input string name, input bch_pkg::gf_elem_t expected,
			input bch_pkg::gf_elem_t actual);
		assert (actual === expected) else begin
			error_count++;
			$display("Error: %s expected 0x%h, got 0x%h", name, expected, actual);
			report_failure();
		end
	endtask

	task automatic check_set(input string name, input bch_pkg::bch_syn_set_t expected,
			input bch_pkg::bch_syn_set_t actual);
		assert (actual === expected) else begin
			error_count++;
			$display("Error: %s expected 0x%h, got 0x%h", name, expected, actual);
			report_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		assert (actual === expected) else begin
			error_count++;
			$display("Error: %s expected 0x%h, got 0x%h", name, expected, actual);
			report_failure();
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			error_count++;
			$display("%s", what);
			report_failure();
		end
	endtask

	task automatic compare_result(input bch_pkg::bch_syn_set_t expected);
		check_elem("syn.s1", expected.s1, syn.s1);
		check_elem("syn.s2", expected.s2, syn.s2);
		check_elem("syn.s3", expected.s3, syn.s3);
		check_elem("syn.s4", expected.s4, syn.s4);
		check_elem("syn.s5", expected.s5, syn.s5);
		check_elem("syn.s6", expected.s6, syn.s6);
		check_flag("error_free", (expected == '0), error_free);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// alpha^i for i = 0..14 over x^4+x+1
	task automatic build_exp_table;
		logic [4:0] a;
		a = 5'b00001;
		for (int i = 0; i < CODE_LEN; i++) begin
			exp_tab[i] = a[3:0];
			a = a << 1;
			if (a[4])
				a = a ^ 5'b10011;
		end
	endtask

	// Sj is the sum of alpha^(i*j) over the set bits r_i
	function automatic bch_pkg::bch_syn_set_t model_syn(input logic [CODE_LEN-1:0] w,
			input int n);
		bch_pkg::gf_elem_t     s [6];
		bch_pkg::bch_syn_set_t r;
		for (int j = 1; j <= 6; j++) begin
			s[j-1] = '0;
			for (int i = 0; i < n; i++) begin
				if (w[i])
					s[j-1] = s[j-1] ^ exp_tab[(i * j) % CODE_LEN];
			end
		end
		r.s1 = s[0];
		r.s2 = s[1];
		r.s3 = s[2];
		r.s4 = s[3];
		r.s5 = s[4];
		r.s6 = s[5];
		return r;
	endfunction

	// Carry-less product of a data polynomial and the generator
	function automatic logic [CODE_LEN-1:0] poly_mul(input logic [4:0] d, input logic [10:0] g);
		logic [CODE_LEN-1:0] p;
		p = '0;
		for (int i = 0; i < 5; i++) begin
			if (d[i])
				p = p ^ ({4'b0000, g} << i);
		end
		return p;
	endfunction

	// Every done is matched against the oldest pending word
	always @(negedge clk) begin
		if (rst_n) begin
			if (done) begin
				check_true(exp_q.size() > 0, "done pulsed with no word pending");
				mon_exp = exp_q.pop_front();
				mon_due = due_q.pop_front();
				check_true(cyc == mon_due, "done did not arrive two cycles after the last bit");
				compare_result(mon_exp);
				held_syn = syn;
				held_ef = error_free;
			end else begin
				check_set("syn (held)", held_syn, syn);
				check_flag("error_free (held)", held_ef, error_free);
				if (due_q.size() > 0)
					check_true(due_q[0] != cyc, "done missing for a completed word");
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Idle cycle with optional junk on the other strobes
	task automatic drive_idle(input logic noisy);
		bit_in.ce = 1'b0;
		bit_in.first = noisy ? 1'($random(seed)) : 1'b0;
		bit_in.last = noisy ? 1'($random(seed)) : 1'b0;
		bit_in.data = noisy ? 1'($random(seed)) : 1'b0;
	endtask

	// Highest power first with random idle gaps of up to max_gap cycles
	task automatic send_word(input logic [CODE_LEN-1:0] w, input int n, input int max_gap);
		int gap;
		for (int i = n - 1; i >= 0; i--) begin
			if (i < n - 1 && max_gap > 0) begin
				gap = $unsigned($random(seed)) % (max_gap + 1);
				repeat (gap) begin
					@(negedge clk);
					drive_idle(1'b1);
				end
			end
			@(negedge clk);
			bit_in.ce = 1'b1;
			bit_in.first = (i == n - 1);
			bit_in.last = (i == 0);
			bit_in.data = w[i];
		end
		exp_q.push_back(model_syn(w, n));
		due_q.push_back(cyc + 2);
	endtask

	task automatic wait_results;
		int waited;
		waited = 0;
		@(negedge clk);
		drive_idle(1'b0);
		while (exp_q.size() > 0 && waited < 8) begin
			@(negedge clk);
			waited++;
		end
		@(negedge clk);
		check_true(exp_q.size() == 0, "no done for a word that was sent");
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic test_reset_state;
		@(negedge clk);
		check_flag("done", 1'b0, done);
		check_flag("error_free", 1'b0, error_free);
		check_set("syn", '0, syn);
	endtask

	task automatic test_zero_and_codeword;
		logic [CODE_LEN-1:0] cw;
		send_word('0, CODE_LEN, 0);
		wait_results();
		check_flag("error_free", 1'b1, error_free);
		cw = poly_mul(5'b10110, GEN_POLY);
		send_word(cw, CODE_LEN, 0);
		wait_results();
		check_flag("error_free", 1'b1, error_free);
	endtask

	task automatic test_single_errors;
		for (int p = 0; p < CODE_LEN; p++) begin
			send_word({{(CODE_LEN-1){1'b0}}, 1'b1} << p, CODE_LEN, 0);
			wait_results();
			check_elem("syn.s1", exp_tab[p], syn.s1);
			check_elem("syn.s3", exp_tab[(3 * p) % CODE_LEN], syn.s3);
		end
	endtask

	task automatic test_random_words;
		logic [CODE_LEN-1:0] w;
		repeat (20) begin
			w = CODE_LEN'($random(seed));
			send_word(w, CODE_LEN, 1);
			wait_results();
		end
	endtask

	// Second word starts on the cycle right after the first one's last bit
	task automatic test_back_to_back;
		logic [CODE_LEN-1:0] a;
		logic [CODE_LEN-1:0] b;
		a = CODE_LEN'($random(seed));
		b = CODE_LEN'($random(seed));
		send_word(a, CODE_LEN, 0);
		send_word(b, CODE_LEN, 0);
		wait_results();
		send_word({{(CODE_LEN-1){1'b0}}, 1'b1}, 1, 0);
		send_word(b, CODE_LEN, 0);
		wait_results();
	endtask

	task automatic test_shortened;
		logic [CODE_LEN-1:0] w;
		w = CODE_LEN'($random(seed)) & 15'h01ff;
		send_word(w, 9, 1);
		wait_results();
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		bit_in = '0;
		seed = 14997;
		error_count = 0;
		build_exp_table();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		test_reset_state();
		test_zero_and_codeword();
		test_single_errors();
		test_random_words();
		test_back_to_back();
		test_shortened();
		if (error_count == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			report_failure();
		end
	end

	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		report_failure();
	end

endmodule

`default_nettype wire

/* bch_syndrome.f */
common/bch_pkg.sv
bch_syndrome/bch_syn_remainder.sv
bch_syndrome/bch_syn_horner.sv
bch_syndrome/bch_syn_assemble.sv
bch_syndrome/bch_syndrome_top.sv
dv/bch_syndrome_chk.sv
dv/bch_syndrome_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the BCH syndrome testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module bch_syndrome_tb \
	-f bch_syndrome.f \
	-o sim_bch_syndrome

# The simulation may stop on an error, the log decides the outcome
./obj_dir/sim_bch_syndrome > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q 'Test failures found' "$LOG"; then
	echo "Simulation FAILED"
	exit 1
fi
if ! grep -q 'All tests passed!' "$LOG"; then
	echo "Simulation FAILED, no pass message in $LOG"
	exit 1
fi
echo "Simulation PASSED"
